//--- filelist.f
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/line_array.sv
verilog/cache_ctrl.sv
verilog/line_memory.sv
verilog/cache_top.sv
verification/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - target: rtl
    files:
      - verilog/cache_pkg.sv
      - verilog/mem_pkg.sv
      - verilog/line_array.sv
      - verilog/cache_ctrl.sv
      - verilog/line_memory.sv
      - verilog/cache_top.sv
  - target: test
    files:
      - verification/cache_tb.sv

//--- verification/cache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

  logic                         clk;
  logic                         reset;
  logic                         is_input_valid;
  logic [cache_pkg::ADDR_W-1:0] addr;
  logic                         mem_rw;
  cache_pkg::word_t             din;
  logic                         is_ready;
  logic                         is_output_valid;
  cache_pkg::word_t             dout;
  logic                         is_hit;

  // One entry of stimulus and expected results per request
  bit                           tbl_rw   [$];
  logic [cache_pkg::ADDR_W-1:0] tbl_addr [$];
  cache_pkg::word_t             tbl_din  [$];
  cache_pkg::word_t             tbl_dout [$];
  bit                           tbl_hit  [$];

  int data_errors;
  int hit_errors;
  int status_errors;
  int cycles;
  int limit;

  cache_top dut0 (
    .clk             (clk),
    .reset           (reset),
    .is_input_valid  (is_input_valid),
    .addr            (addr),
    .mem_rw          (mem_rw),
    .din             (din),
    .is_ready        (is_ready),
    .is_output_valid (is_output_valid),
    .dout            (dout),
    .is_hit          (is_hit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic add_entry(input bit rw, input logic [cache_pkg::ADDR_W-1:0] a,
                           input cache_pkg::word_t d, input cache_pkg::word_t exp_d,
                           input bit exp_h);
    tbl_rw.push_back(rw);
    tbl_addr.push_back(a);
    tbl_din.push_back(d);
    tbl_dout.push_back(exp_d);
    tbl_hit.push_back(exp_h);
  endtask

  task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                            input int idx);
    if (got !== exp) begin
      $display("Error at %0t: entry %0d read 0x%08h, expected 0x%08h", $time, idx, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_hit(input logic got, input bit exp, input int idx);
    if (got !== exp) begin
      $display("Error at %0t: entry %0d is_hit %0b, expected %0b", $time, idx, got, exp);
      hit_errors++;
    end
  endtask

  // Idle strobes expected once reset has been released
  task automatic check_status(input logic got_ready, input logic got_valid);
    if (got_ready !== 1'b1 || got_valid !== 1'b0) begin
      $display("Error at %0t: after reset is_ready %0b, is_output_valid %0b", $time,
               got_ready, got_valid);
      status_errors++;
    end
  endtask

  // One request through the strobe handshake on falling edges
  task automatic run_request(input int idx);
    while (!is_ready) @(negedge clk);
    addr           = tbl_addr[idx];
    mem_rw         = tbl_rw[idx];
    din            = tbl_din[idx];
    is_input_valid = 1'b1;
    @(negedge clk);
    is_input_valid = 1'b0;
    while (!is_output_valid) @(negedge clk);
    check_hit(is_hit, tbl_hit[idx], idx);
    if (!tbl_rw[idx]) check_word(dout, tbl_dout[idx], idx);
    @(negedge clk);
  endtask

  task automatic build_table();
    // Cold reads return zero from a cleared memory
    add_entry(1'b0, 32'h0000_0100, '0, 32'h0000_0000, 1'b0);
    add_entry(1'b0, 32'h0000_0a40, '0, 32'h0000_0000, 1'b0);
    // Write-allocate, then hit
    add_entry(1'b1, 32'h0000_0210, 32'hdead_beef, '0, 1'b0);
    add_entry(1'b0, 32'h0000_0210, '0, 32'hdead_beef, 1'b1);
    // All four offsets of set 2
    add_entry(1'b1, 32'h0000_0328, 32'h1111_2222, '0, 1'b0);
    add_entry(1'b1, 32'h0000_0320, 32'h3333_4444, '0, 1'b1);
    add_entry(1'b1, 32'h0000_032c, 32'h5555_6666, '0, 1'b1);
    add_entry(1'b1, 32'h0000_0324, 32'h7777_8888, '0, 1'b1);
    add_entry(1'b0, 32'h0000_032c, '0, 32'h5555_6666, 1'b1);
    add_entry(1'b0, 32'h0000_0320, '0, 32'h3333_4444, 1'b1);
    add_entry(1'b0, 32'h0000_0328, '0, 32'h1111_2222, 1'b1);
    add_entry(1'b0, 32'h0000_0324, '0, 32'h7777_8888, 1'b1);
    // Dirty eviction, then the old line comes back from memory
    add_entry(1'b0, 32'h0000_0520, '0, 32'h0000_0000, 1'b0);
    add_entry(1'b0, 32'h0000_0328, '0, 32'h1111_2222, 1'b0);
    add_entry(1'b0, 32'h0000_032c, '0, 32'h5555_6666, 1'b1);
    // Tag 7 set 2 is line 0x72, which aliases line 0x32
    add_entry(1'b0, 32'h0000_0720, '0, 32'h3333_4444, 1'b0);
    // Clean eviction of set 4, reload, store, load
    add_entry(1'b0, 32'h0000_0b40, '0, 32'h0000_0000, 1'b0);
    add_entry(1'b0, 32'h0000_0a44, '0, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 32'h0000_0a44, 32'hcafe_f00d, '0, 1'b1);
    add_entry(1'b0, 32'h0000_0a44, '0, 32'hcafe_f00d, 1'b1);
    add_entry(1'b0, 32'h0000_0a40, '0, 32'h0000_0000, 1'b1);
  endtask

  // Run limit scales with the table
  initial begin
    cycles = 0;
    @(negedge reset);
    limit = tbl_rw.size() * 20;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: no response from the cache after %0d cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int total;
    reset          = 1'b1;
    is_input_valid = 1'b0;
    addr           = '0;
    mem_rw         = 1'b0;
    din            = '0;
    data_errors    = 0;
    hit_errors     = 0;
    status_errors  = 0;
    build_table();

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    @(negedge clk);
    check_status(is_ready, is_output_valid);

    for (int i = 0; i < tbl_rw.size(); i++) begin
      run_request(i);
    end

    total = data_errors + hit_errors + status_errors;
    $display("Errors: %0d data, %0d hit, %0d status, %0d total", data_errors, hit_errors,
             status_errors, total);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         is_input_valid,
  input  logic [cache_pkg::ADDR_W-1:0] addr,
  input  logic                         mem_rw,
  input  cache_pkg::word_t             din,
  output logic                         is_ready,
  output logic                         is_output_valid,
  output cache_pkg::word_t             dout,
  output logic                         is_hit
);

  cache_pkg::index_t  tag_index;
  logic               tag_we;
  cache_pkg::tag_t    tag_wdata;
  cache_pkg::tag_t    tag_rdata;
  cache_pkg::index_t  data_index;
  logic               data_we;
  mem_pkg::line_t     data_wdata;
  mem_pkg::line_t     data_rdata;

  logic               mem_req;
  logic               mem_we;
  mem_pkg::mem_addr_t mem_addr;
  mem_pkg::line_t     mem_wdata;
  logic               mem_ready;
  logic               mem_rvalid;
  mem_pkg::line_t     mem_rdata;

  cache_ctrl ctrl0 (
    .clk             (clk),
    .reset           (reset),
    .is_input_valid  (is_input_valid),
    .addr            (addr),
    .mem_rw          (mem_rw),
    .din             (din),
    .is_ready        (is_ready),
    .is_output_valid (is_output_valid),
    .dout            (dout),
    .is_hit          (is_hit),
    .tag_index       (tag_index),
    .tag_we          (tag_we),
    .tag_wdata       (tag_wdata),
    .tag_rdata       (tag_rdata),
    .data_index      (data_index),
    .data_we         (data_we),
    .data_wdata      (data_wdata),
    .data_rdata      (data_rdata),
    .mem_req         (mem_req),
    .mem_we          (mem_we),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_ready       (mem_ready),
    .mem_rvalid      (mem_rvalid),
    .mem_rdata       (mem_rdata)
  );

  line_array #(.entry_t(cache_pkg::tag_t)) tag_store (
    .clk   (clk),
    .index (tag_index),
    .we    (tag_we),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

  line_array #(.entry_t(mem_pkg::line_t)) data_store (
    .clk   (clk),
    .index (data_index),
    .we    (data_we),
    .wdata (data_wdata),
    .rdata (data_rdata)
  );

  line_memory mem0 (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

endmodule

`default_nettype wire

//--- verilog/line_memory.sv
`timescale 1ns/100ps
`default_nettype none

// Line-wide backing store with a fixed access latency
module line_memory (
  input  logic               clk,
  input  logic               reset,
  input  logic               mem_req,
  input  logic               mem_we,
  input  mem_pkg::mem_addr_t mem_addr,
  input  mem_pkg::line_t     mem_wdata,
  output logic               mem_ready,
  output logic               mem_rvalid,
  output mem_pkg::line_t     mem_rdata
);

  mem_pkg::line_t     lines [mem_pkg::MEM_LINES];

  mem_pkg::lat_cnt_t  lat_cnt;     // Nonzero while an access is in flight
  logic               pend_we;
  mem_pkg::mem_addr_t pend_addr;
  mem_pkg::line_t     pend_wdata;
  logic               accept;
  logic               last_cycle;

  assign mem_ready  = (lat_cnt == '0);
  assign accept     = mem_req && mem_ready;
  assign last_cycle = (lat_cnt == mem_pkg::lat_cnt_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      lat_cnt    <= '0;
      pend_we    <= 1'b0;
      mem_rvalid <= 1'b0;
      for (int i = 0; i < mem_pkg::MEM_LINES; i++) begin
        lines[i] <= '0;
      end
    end else begin
      mem_rvalid <= 1'b0;
      if (accept) begin
        lat_cnt <= mem_pkg::lat_cnt_t'(mem_pkg::MEM_LATENCY);
        pend_we <= mem_we;
      end else if (!mem_ready) begin
        lat_cnt <= lat_cnt - 1'b1;
        if (last_cycle) begin
          if (pend_we) lines[pend_addr] <= pend_wdata;   // Write lands at expiry
          else mem_rvalid <= 1'b1;    // Pulses as mem_ready returns
        end
      end
    end
  end

  // Request payload and read data
  always_ff @(posedge clk) begin
    if (accept) begin
      pend_addr  <= mem_addr;
      pend_wdata <= mem_wdata;
    end
    if (last_cycle && !pend_we) begin
      mem_rdata <= lines[pend_addr];
    end
  end

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
  input  logic                          clk,
  input  logic                          reset,

  // Processor side
  input  logic                          is_input_valid,
  input  logic [cache_pkg::ADDR_W-1:0]  addr,
  input  logic                          mem_rw,          // 0 read, 1 write
  input  cache_pkg::word_t              din,
  output logic                          is_ready,
  output logic                          is_output_valid,
  output cache_pkg::word_t              dout,
  output logic                          is_hit,

  // Tag and data arrays
  output cache_pkg::index_t             tag_index,
  output logic                          tag_we,
  output cache_pkg::tag_t               tag_wdata,
  input  cache_pkg::tag_t               tag_rdata,
  output cache_pkg::index_t             data_index,
  output logic                          data_we,
  output mem_pkg::line_t                data_wdata,
  input  mem_pkg::line_t                data_rdata,

  // Backing memory
  output logic                          mem_req,
  output logic                          mem_we,
  output mem_pkg::mem_addr_t            mem_addr,
  output mem_pkg::line_t                mem_wdata,
  input  logic                          mem_ready,
  input  logic                          mem_rvalid,
  input  mem_pkg::line_t                mem_rdata
);

  cache_pkg::cache_state_t state;

  cache_pkg::tag_t    req_tag;
  cache_pkg::index_t  req_index;
  cache_pkg::offset_t req_offset;

  logic [cache_pkg::NUM_SETS-1:0] valid;
  logic [cache_pkg::NUM_SETS-1:0] dirty;
  logic                           missed;   // Request has seen a failed compare
  logic                           hit;

  mem_pkg::line_t merged;
  logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0] line_addr;

  assign req_offset = addr[cache_pkg::BYTE_OFF_W +: cache_pkg::OFFSET_W];
  assign req_index  = addr[cache_pkg::BYTE_OFF_W + cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign req_tag    = addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];

  assign tag_index  = req_index;
  assign data_index = req_index;
  assign tag_wdata  = req_tag;    // Only written on refill
  assign mem_wdata  = data_rdata; // Victim line on write-back

  assign hit      = valid[req_index] && (tag_rdata == req_tag);
  assign is_ready = (state == cache_pkg::IDLE);
  assign is_hit   = (state == cache_pkg::COMPARE) && hit && !missed;

  // Aliases modulo MEM_LINES
  assign mem_addr = line_addr[mem_pkg::MEM_ADDR_W-1:0];

  always_comb begin
    dout   = data_rdata[req_offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];
    merged = data_rdata;
    merged[req_offset*cache_pkg::WORD_W +: cache_pkg::WORD_W] = din;  // Store merge
  end

  always_comb begin
    is_output_valid = 1'b0;
    tag_we          = 1'b0;
    data_we         = 1'b0;
    data_wdata      = merged;
    mem_req         = 1'b0;
    mem_we          = 1'b0;
    line_addr       = {req_tag, req_index};
    case (state)
      cache_pkg::COMPARE: begin
        if (hit) begin
          is_output_valid = 1'b1;
          data_we         = mem_rw;
        end
      end
      cache_pkg::WRITE_BACK: begin
        mem_req   = 1'b1;
        mem_we    = 1'b1;
        line_addr = {tag_rdata, req_index};   // Victim's own address
      end
      cache_pkg::ALLOCATE: begin
        mem_req = 1'b1;
      end
      cache_pkg::ALLOC_WAIT: begin
        if (mem_rvalid) begin
          tag_we     = 1'b1;
          data_we    = 1'b1;
          data_wdata = mem_rdata;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= cache_pkg::IDLE;
      valid  <= '0;
      dirty  <= '0;
      missed <= 1'b0;
    end else begin
      case (state)
        cache_pkg::IDLE: begin
          if (is_input_valid) begin
            state  <= cache_pkg::COMPARE;
            missed <= 1'b0;
          end
        end
        cache_pkg::COMPARE: begin
          if (hit) begin
            if (mem_rw) begin
              dirty[req_index] <= 1'b1;
            end
            state <= cache_pkg::IDLE;
          end else begin
            missed <= 1'b1;
            // Clean or empty sets skip the write-back
            if (valid[req_index] && dirty[req_index]) state <= cache_pkg::WRITE_BACK;
            else state <= cache_pkg::ALLOCATE;
          end
        end
        cache_pkg::WRITE_BACK: begin
          if (mem_ready) state <= cache_pkg::WB_WAIT;
        end
        cache_pkg::WB_WAIT: begin
          if (mem_ready) state <= cache_pkg::ALLOCATE;   // Write has landed
        end
        cache_pkg::ALLOCATE: begin
          if (mem_ready) state <= cache_pkg::ALLOC_WAIT;
        end
        cache_pkg::ALLOC_WAIT: begin
          if (mem_rvalid) begin
            valid[req_index] <= 1'b1;
            dirty[req_index] <= 1'b0;
            state            <= cache_pkg::COMPARE;
          end
        end
        default: state <= cache_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/line_array.sv
`timescale 1ns/100ps
`default_nettype none

// One entry per set, written on the clock edge and read combinationally
module line_array #(
  parameter type entry_t = cache_pkg::word_t
) (
  input  logic              clk,
  input  cache_pkg::index_t index,
  input  logic              we,
  input  entry_t            wdata,
  output entry_t            rdata
);

  entry_t entries [cache_pkg::NUM_SETS];

  always_ff @(posedge clk) begin
    if (we) begin
      entries[index] <= wdata;
    end
  end

  // Contents are qualified by the controller's valid bits
  assign rdata = entries[index];

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int LINE_W = cache_pkg::LINE_WORDS * cache_pkg::WORD_W;  // 128 bits

  localparam int MEM_LATENCY = 4;    // Busy cycles per access
  localparam int MEM_LINES   = 64;
  localparam int MEM_ADDR_W  = $clog2(MEM_LINES);
  localparam int LAT_W       = $clog2(MEM_LATENCY + 1);

  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [LAT_W-1:0]      lat_cnt_t;   // Latency down-counter

endpackage

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // Processor word and address
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // Geometry of the direct-mapped array
  localparam int LINE_WORDS = 4;
  localparam int NUM_SETS   = 16;

  // Address split into tag | index | word offset | byte offset
  localparam int BYTE_OFF_W = 2;
  localparam int OFFSET_W   = 2;   // log2 of LINE_WORDS
  localparam int INDEX_W    = 4;   // log2 of NUM_SETS
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // Miss handling walks WRITE_BACK only for a dirty victim
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITE_BACK,
    WB_WAIT,
    ALLOCATE,
    ALLOC_WAIT
  } cache_state_t;

endpackage

`default_nettype wire
